// ==== tb.f ====
+incdir+common
common/ring_pkg.sv
common/apb_pkg.sv
ring_buffer/ring_writer.sv
ring_buffer/frame_reader.sv
verilog/ring_ram.sv
verilog/ring_regs.sv
verilog/ring_capture_top.sv
test/ring_capture_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ring capture testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --top-module ring_capture_tb \
    -f tb.f --Mdir obj_dir -o ring_capture_sim

./obj_dir/ring_capture_sim | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== test/ring_capture_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ring_config.svh"

module ring_capture_tb
    import apb_pkg::*;
    import ring_pkg::*;
();

    localparam int CLK_HALF     = 4;
    localparam int BEAT_TIMEOUT = 200;
    localparam int IDLE_TIMEOUT = 50;
    localparam int NUM_ROWS     = 7;

    // One frame per row
    // ready_level 4 keeps frame_ready high
    typedef struct packed {
        int samples;
        int stride;
        int length;
        int ready_level;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{100, 1, 100, 4},
        '{60, 4, 39, 2},
        '{200, 1, 256, 3},
        '{37, 4, 64, 4},
        '{300, 7, 100, 1},
        '{5, 255, 1, 2},
        '{0, 3, 20, 2}
    };

    logic        clk;
    logic        reset_b;
    sample_in_t  sample_in;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        frame_valid;
    frame_beat_t frame_beat;
    logic        frame_ready;

    // Ring reference model
    sample_t     model [`RING_DEPTH];
    ring_addr_t  wr_ptr;
    ring_addr_t  head_exp;
    int          total;
    int          errors;
    int          timeouts;
    int          seed;
    apb_rsp_t    rsp;

    ring_capture_top ring_capture_top_inst (
        .clk         (clk),
        .reset_b     (reset_b),
        .sample_in   (sample_in),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .frame_valid (frame_valid),
        .frame_beat  (frame_beat),
        .frame_ready (frame_ready)
    );

    always #CLK_HALF clk = ~clk;

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic note_timeout(input string what);
        timeouts++;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic check_beat(input string name, input frame_beat_t got,
                              input frame_beat_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s: data %h last %h, expected data %h last %h",
                     name, got.data, got.last, exp.data, exp.last);
        end
    endtask

    task automatic check_apb(input string name, input apb_rsp_t got,
                             input logic [31:0] exp_data, input logic exp_err);
        if (got.prdata !== exp_data || got.pslverr !== exp_err || got.pready !== 1'b1) begin
            errors++;
            $display("ERR %s: prdata %h pslverr %h pready %h, expected prdata %h pslverr %h",
                     name, got.prdata, got.pslverr, got.pready, exp_data, exp_err);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////
    // APB and sample drivers
    //////////////////////////////

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] data, output apb_rsp_t got);
        int wait_cnt;
        wait_cnt = 0;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready && wait_cnt < IDLE_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!apb_rsp.pready) begin
            note_timeout("APB pready");
        end
        got = apb_rsp;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic write_reg(input string name, input logic [7:0] addr,
                             input logic [31:0] data);
        apb_rsp_t got;
        apb_access(1'b1, addr, data, got);
        check_apb(name, got, 32'd0, 1'b0);
    endtask

    task automatic read_expect(input string name, input logic [7:0] addr,
                               input logic [31:0] exp_data);
        apb_rsp_t got;
        apb_access(1'b0, addr, 32'd0, got);
        check_apb(name, got, exp_data, 1'b0);
    endtask

    task automatic push_samples(input int count);
        sample_t d;
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            d = $random(seed);
            sample_in.valid <= 1'b1;
            sample_in.data  <= d;
            model[wr_ptr] = d;
            wr_ptr = wr_ptr + 1'b1;
            total++;
        end
        @(posedge clk);
        sample_in.valid <= 1'b0;
    endtask

    //////////////////////////////
    // Frame collection
    //////////////////////////////

    task automatic collect_frame(input ring_addr_t head0, input int stride,
                                 input int length, input int ready_level);
        int          k;
        int          idle;
        int          addr;
        logic        rdy;
        logic        held_valid;
        frame_beat_t held;
        frame_beat_t exp;
        k = 0;
        idle = 0;
        held_valid = 1'b0;
        held = '0;
        while (k < length && idle < BEAT_TIMEOUT) begin
            @(posedge clk);
            rdy = (($random(seed) & 3) < ready_level);
            frame_ready <= rdy;
            @(negedge clk);
            if (frame_valid) begin
                addr = (int'(head0) + k * stride) % `RING_DEPTH;
                exp.data = model[ring_addr_t'(addr)];
                exp.last = (k == length - 1);
                if (frame_ready) begin
                    check_beat("frame_beat", frame_beat, exp);
                    // Beat seen during the stall must be the one transferred
                    if (held_valid) begin
                        check_beat("frame_beat held", held, frame_beat);
                    end
                    held_valid = 1'b0;
                    k++;
                    idle = 0;
                end else begin
                    held = frame_beat;
                    held_valid = 1'b1;
                    idle++;
                end
            end else begin
                idle++;
            end
        end
        if (k < length) begin
            note_timeout("frame beats");
        end
        @(posedge clk);
        frame_ready <= 1'b0;
    endtask

    task automatic wait_idle();
        int       cnt;
        apb_rsp_t got;
        cnt = 0;
        apb_access(1'b0, `REG_STATUS_OFS, 32'd0, got);
        while (got.prdata[1] && cnt < IDLE_TIMEOUT) begin
            apb_access(1'b0, `REG_STATUS_OFS, 32'd0, got);
            cnt++;
        end
        if (got.prdata[1]) begin
            note_timeout("busy to clear");
        end
    endtask

    task automatic run_row(input row_t row);
        apb_rsp_t got;
        logic     wrapped_exp;
        push_samples(row.samples);
        wrapped_exp = (total >= `RING_DEPTH);
        head_exp = wrapped_exp ? wr_ptr : '0;
        apb_access(1'b0, `REG_STATUS_OFS, 32'd0, got);
        check_flag("status.wrapped", got.prdata[0], wrapped_exp);
        check_apb("status", got, {31'd0, wrapped_exp}, 1'b0);
        write_reg("stride write", `REG_STRIDE_OFS, 32'(row.stride));
        write_reg("length write", `REG_LENGTH_OFS, 32'(row.length));
        read_expect("stride", `REG_STRIDE_OFS, 32'(row.stride));
        read_expect("length", `REG_LENGTH_OFS, 32'(row.length));
        write_reg("ctrl start", `REG_CTRL_OFS, 32'd1);
        collect_frame(head_exp, row.stride, row.length, row.ready_level);
        wait_idle();
        @(negedge clk);
        check_flag("frame_valid", frame_valid, 1'b0);
    endtask

    // Second start lands while the first frame is still being read
    task automatic overrun_test();
        write_reg("stride write", `REG_STRIDE_OFS, 32'd1);
        write_reg("length write", `REG_LENGTH_OFS, 32'd8);
        frame_ready <= 1'b0;
        head_exp = wr_ptr;
        write_reg("ctrl start", `REG_CTRL_OFS, 32'd1);
        write_reg("ctrl second start", `REG_CTRL_OFS, 32'd1);
        read_expect("status overrun", `REG_STATUS_OFS, 32'h7);
        collect_frame(head_exp, 1, 8, 4);
        wait_idle();
        read_expect("status after frame", `REG_STATUS_OFS, 32'h5);
        write_reg("ctrl clear", `REG_CTRL_OFS, 32'h2);
        read_expect("status cleared", `REG_STATUS_OFS, 32'h1);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        clk         = 1'b0;
        reset_b     = 1'b0;
        sample_in   = '0;
        apb_req     = '0;
        frame_ready = 1'b0;
        seed        = 57286;
        wr_ptr      = '0;
        head_exp    = '0;
        total       = 0;
        errors      = 0;
        timeouts    = 0;
        repeat (4) @(posedge clk);
        reset_b <= 1'b1;

        @(negedge clk);
        check_flag("frame_valid", frame_valid, 1'b0);
        read_expect("status", `REG_STATUS_OFS, 32'd0);
        read_expect("stride", `REG_STRIDE_OFS, 32'd1);

        // Offsets outside the register map
        apb_access(1'b0, 8'h10, 32'd0, rsp);
        check_apb("unknown read", rsp, 32'd0, 1'b1);
        apb_access(1'b1, 8'h14, 32'hFFFF_FFFF, rsp);
        check_apb("unknown write", rsp, 32'd0, 1'b1);

        for (int r = 0; r < NUM_ROWS && timeouts == 0; r++) begin
            run_row(ROWS[r]);
        end
        if (timeouts == 0) begin
            overrun_test();
        end

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/ring_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ring_capture_top
    import apb_pkg::*;
    import ring_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_b,
    input  wire sample_in_t sample_in,
    input  wire apb_req_t   apb_req,
    output apb_rsp_t        apb_rsp,
    output logic            frame_valid,
    output frame_beat_t     frame_beat,
    input  wire logic       frame_ready
);

    ram_wr_t    ram_wr;
    ram_rd_t    ram_rd;
    sample_t    ram_data;
    ring_addr_t head;
    logic       wrapped;
    logic       busy;
    logic       start;
    frame_cfg_t frame_cfg;

    //////////////////////////////
    // Control and status
    //////////////////////////////

    ring_regs ring_regs_inst (
        .clk     (clk),
        .reset_b (reset_b),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .wrapped (wrapped),
        .busy    (busy),
        .start   (start),
        .cfg     (frame_cfg)
    );

    //////////////////////////////
    // Datapath
    //////////////////////////////

    ring_writer ring_writer_inst (
        .clk       (clk),
        .reset_b   (reset_b),
        .sample_in (sample_in),
        .ram_wr    (ram_wr),
        .head      (head),
        .wrapped   (wrapped)
    );

    frame_reader frame_reader_inst (
        .clk         (clk),
        .reset_b     (reset_b),
        .start       (start),
        .cfg         (frame_cfg),
        .head        (head),
        .ram_rd      (ram_rd),
        .ram_data    (ram_data),
        .frame_valid (frame_valid),
        .frame_beat  (frame_beat),
        .frame_ready (frame_ready),
        .busy        (busy)
    );

    ring_ram ring_ram_inst (
        .clk     (clk),
        .wr      (ram_wr),
        .rd      (ram_rd),
        .rd_data (ram_data)
    );

endmodule

`default_nettype wire

// ==== verilog/ring_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ring_config.svh"

module ring_regs
    import apb_pkg::*;
    import ring_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset_b,
    input  wire apb_req_t apb_req,
    output apb_rsp_t      apb_rsp,
    input  wire logic     wrapped,
    input  wire logic     busy,
    output logic          start,
    output frame_cfg_t    cfg
);

    logic [7:0]  stride;
    logic [8:0]  length;
    logic        overrun;
    logic        access;
    logic        wr_en;
    logic        addr_hit;
    logic [31:0] rd_data;

    // Access phase with pready always high
    assign access = apb_req.psel && apb_req.penable;
    assign wr_en  = access && apb_req.pwrite;

    //////////////////////////////
    // Register writes
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            stride  <= 8'd1;
            length  <= 9'(`RING_DEPTH);
            overrun <= 1'b0;
            start   <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wr_en) begin
                case (reg_addr_e'(apb_req.paddr))
                    CTRL: begin
                        if (apb_req.pwdata[1]) begin
                            overrun <= 1'b0;
                        end
                        // Start while a frame is running is dropped
                        if (apb_req.pwdata[0]) begin
                            if (busy || start) begin
                                overrun <= 1'b1;
                            end else begin
                                start <= 1'b1;
                            end
                        end
                    end
                    STRIDE: stride <= apb_req.pwdata[7:0];
                    LENGTH: length <= apb_req.pwdata[8:0];
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////
    // Read mux and response
    //////////////////////////////

    always_comb begin
        rd_data  = '0;
        addr_hit = 1'b1;
        case (reg_addr_e'(apb_req.paddr))
            CTRL:    rd_data = '0;
            STATUS:  rd_data = {29'd0, overrun, busy, wrapped};
            STRIDE:  rd_data = {24'd0, stride};
            LENGTH:  rd_data = {23'd0, length};
            default: addr_hit = 1'b0;
        endcase
    end

    assign apb_rsp.prdata  = (apb_req.psel && !apb_req.pwrite) ? rd_data : '0;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && !addr_hit;

    assign cfg.stride = stride;
    assign cfg.length = length;

    a_start_pulse: assert property (
        @(posedge clk) disable iff (!reset_b)
        start |=> !start
    ) else $error("start held longer than one cycle");

endmodule

`default_nettype wire

// ==== verilog/ring_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ring_config.svh"

module ring_ram
    import ring_pkg::*;
(
    input  wire logic    clk,
    input  wire ram_wr_t wr,
    input  wire ram_rd_t rd,
    output sample_t      rd_data
);

    sample_t mem [`RING_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Registered read returns old data on a same-address collision
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

// ==== ring_buffer/frame_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_reader
    import ring_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_b,
    input  wire logic       start,
    input  wire frame_cfg_t cfg,
    input  wire ring_addr_t head,
    output ram_rd_t         ram_rd,
    input  wire sample_t    ram_data,
    output logic            frame_valid,
    output frame_beat_t     frame_beat,
    input  wire logic       frame_ready,
    output logic            busy
);

    reader_state_e state_q;
    ring_addr_t    rd_addr;
    logic [8:0]    beat_cnt;
    logic [7:0]    stride_q;
    logic [8:0]    length_q;
    logic          xfer;

    assign xfer = frame_valid && frame_ready;

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state_q     <= IDLE;
            rd_addr     <= '0;
            beat_cnt    <= '0;
            frame_valid <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start) begin
                        rd_addr  <= head;
                        beat_cnt <= '0;
                        state_q  <= ISSUE;
                    end
                end
                ISSUE: begin
                    state_q <= WAIT_DATA;
                end
                WAIT_DATA: begin
                    frame_valid <= 1'b1;
                    state_q     <= HOLD;
                end
                HOLD: begin
                    if (xfer) begin
                        frame_valid <= 1'b0;
                        if (frame_beat.last) begin
                            state_q <= IDLE;
                        end else begin
                            // Step through the ring mod 256
                            rd_addr  <= rd_addr + stride_q;
                            beat_cnt <= beat_cnt + 1'b1;
                            state_q  <= ISSUE;
                        end
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Frame setup captured at start
    always_ff @(posedge clk) begin
        if (state_q == IDLE && start) begin
            stride_q <= cfg.stride;
            length_q <= cfg.length;
        end
    end

    // Output register loaded when RAM data returns
    always_ff @(posedge clk) begin
        if (state_q == WAIT_DATA) begin
            frame_beat.data <= ram_data;
            frame_beat.last <= (beat_cnt == length_q - 9'd1);
        end
    end

    assign ram_rd.en   = (state_q == ISSUE);
    assign ram_rd.addr = rd_addr;
    assign busy        = (state_q != IDLE);

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_beat_stable: assert property (
        @(posedge clk) disable iff (!reset_b)
        frame_valid && !frame_ready |=> frame_valid && $stable(frame_beat)
    ) else $error("frame_beat changed during a stall");

endmodule

`default_nettype wire

// ==== ring_buffer/ring_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ring_writer
    import ring_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_b,
    input  wire sample_in_t sample_in,
    output ram_wr_t         ram_wr,
    output ring_addr_t      head,
    output logic            wrapped
);

    writer_state_e state_q;
    ring_addr_t    wr_ptr;

    //////////////////////////////
    // Write pointer
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wr_ptr <= '0;
        end else if (sample_in.valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Leaves FILLING once address 255 has been written
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state_q <= FILLING;
        end else begin
            case (state_q)
                FILLING: begin
                    if (sample_in.valid && wr_ptr == '1) begin
                        state_q <= WRAPPED;
                    end
                end
                default: begin
                    state_q <= WRAPPED;
                end
            endcase
        end
    end

    // Sample goes straight into the RAM on the edge where it is valid
    assign ram_wr.en   = sample_in.valid;
    assign ram_wr.addr = wr_ptr;
    assign ram_wr.data = sample_in.data;

    // Oldest word sits at the write pointer after a wrap
    assign wrapped = (state_q == WRAPPED);
    assign head    = wrapped ? wr_ptr : '0;

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_ptr_moves_on_valid: assert property (
        @(posedge clk) disable iff (!reset_b)
        !sample_in.valid |=> wr_ptr == $past(wr_ptr)
    ) else $error("wr_ptr moved without a valid sample");

endmodule

`default_nettype wire

// ==== common/apb_pkg.sv ====
`default_nettype none

`include "ring_config.svh"

package apb_pkg;

    // Master to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    //////////////////////////////
    // Register map
    //////////////////////////////

    typedef enum logic [7:0] {
        CTRL   = `REG_CTRL_OFS,
        STATUS = `REG_STATUS_OFS,
        STRIDE = `REG_STRIDE_OFS,
        LENGTH = `REG_LENGTH_OFS
    } reg_addr_e;

endpackage

`default_nettype wire

// ==== common/ring_pkg.sv ====
`default_nettype none

`include "ring_config.svh"

package ring_pkg;

    //////////////////////////////
    // Basic words
    //////////////////////////////

    typedef logic [`RING_DATA_W-1:0] sample_t;
    typedef logic [`RING_ADDR_W-1:0] ring_addr_t;

    // Sample input, no back-pressure
    typedef struct packed {
        logic    valid;
        sample_t data;
    } sample_in_t;

    //////////////////////////////
    // RAM ports
    //////////////////////////////

    typedef struct packed {
        logic       en;
        ring_addr_t addr;
        sample_t    data;
    } ram_wr_t;

    typedef struct packed {
        logic       en;
        ring_addr_t addr;
    } ram_rd_t;

    // Frame setup, length runs 1 to 256
    typedef struct packed {
        logic [7:0] stride;
        logic [8:0] length;
    } frame_cfg_t;

    // One beat of the frame stream
    typedef struct packed {
        sample_t data;
        logic    last;
    } frame_beat_t;

    typedef enum logic {
        FILLING,
        WRAPPED
    } writer_state_e;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_DATA,
        HOLD
    } reader_state_e;

endpackage

`default_nettype wire

// ==== common/ring_config.svh ====
`ifndef RING_CONFIG_SVH
`define RING_CONFIG_SVH

//////////////////////////////
// Ring sizes
//////////////////////////////

// Sample word width
`define RING_DATA_W 32
// Ring address width, depth is 2**RING_ADDR_W
`define RING_ADDR_W 8
`define RING_DEPTH 256

//////////////////////////////
// APB register byte offsets
//////////////////////////////

`define REG_CTRL_OFS   8'h00
`define REG_STATUS_OFS 8'h04
`define REG_STRIDE_OFS 8'h08
`define REG_LENGTH_OFS 8'h0C

`endif
